/* design/displayPkg.sv */
`default_nettype none

package displayPkg;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    // scan count, object position, size or border thickness in pixels
    typedef logic [9:0] coord_t;

    // colour select code as seen by the colour mux
    typedef logic [2:0] selCode_t;

    //////////////////////////////////////////////////////////////////////
    // visible window of the 800x525 scan
    //////////////////////////////////////////////////////////////////////

    // horizontal limits, both inclusive
    localparam coord_t H_ACTIVE_START = 10'd144;
    localparam coord_t H_ACTIVE_END   = 10'd784;

    // vertical limits, both inclusive
    localparam coord_t V_ACTIVE_START = 10'd35;
    localparam coord_t V_ACTIVE_END   = 10'd515;

    //////////////////////////////////////////////////////////////////////
    // fixed select codes
    //////////////////////////////////////////////////////////////////////

    // nothing drawn
    localparam selCode_t SEL_BLANK  = 3'd0;
    localparam selCode_t SEL_BORDER = 3'd6;

    // rectangles per layer (walls, scrolls)
    localparam int NUM_OBJECTS = 8;

endpackage : displayPkg

`default_nettype wire

/* design/objectHitTest.sv */
`default_nettype none

// inside test for one rectangle placed relative to the visible origin
module objectHitTest
(
    input  wire displayPkg::coord_t hCount,
    input  wire displayPkg::coord_t vCount,
    input  wire displayPkg::coord_t posH,
    input  wire displayPkg::coord_t posV,
    input  wire displayPkg::coord_t width,
    input  wire displayPkg::coord_t height,
    output logic                    hit
);
    import displayPkg::*;

    // two spare bits so origin + position + size never wraps
    typedef logic [$bits(coord_t)+1:0] edge_t;

    edge_t leftEdge;
    edge_t rightEdge;
    edge_t topEdge;
    edge_t bottomEdge;

    // absolute edges in scan counts
    always_comb
    begin
        leftEdge   = edge_t'(H_ACTIVE_START) + edge_t'(posH);
        rightEdge  = leftEdge + edge_t'(width);
        topEdge    = edge_t'(V_ACTIVE_START) + edge_t'(posV);
        bottomEdge = topEdge + edge_t'(height);
    end

    // both bounds inclusive, so size 0 still covers the corner pixel
    assign hit = (edge_t'(hCount) >= leftEdge) && (edge_t'(hCount) <= rightEdge)
              && (edge_t'(vCount) >= topEdge)  && (edge_t'(vCount) <= bottomEdge);

endmodule : objectHitTest

`default_nettype wire

/* design/layerPriority.sv */
`default_nettype none

// one layer of rectangles, lowest index wins on overlap
module layerPriority
(
    input  wire displayPkg::coord_t   hCount,
    input  wire displayPkg::coord_t   vCount,
    input  wire displayPkg::coord_t   posH   [displayPkg::NUM_OBJECTS],
    input  wire displayPkg::coord_t   posV   [displayPkg::NUM_OBJECTS],
    input  wire displayPkg::coord_t   width  [displayPkg::NUM_OBJECTS],
    input  wire displayPkg::coord_t   height [displayPkg::NUM_OBJECTS],
    input  wire displayPkg::selCode_t color  [displayPkg::NUM_OBJECTS],
    output logic                      anyHit,
    output displayPkg::selCode_t      hitColor
);
    import displayPkg::*;

    logic [NUM_OBJECTS-1:0] hits;

    //////////////////////////////////////////////////////////////////////
    // per-object rectangle tests
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_OBJECTS; i++)
    begin : gObject
        objectHitTest uHit
        (
            .hCount (hCount),
            .vCount (vCount),
            .posH   (posH[i]),
            .posV   (posV[i]),
            .width  (width[i]),
            .height (height[i]),
            .hit    (hits[i])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // priority pick
    //////////////////////////////////////////////////////////////////////

    assign anyHit = |hits;

    // walk from the top index down so the lowest hit is written last
    always_comb
    begin
        hitColor = SEL_BLANK;
        for (int i = NUM_OBJECTS - 1; i >= 0; i--)
        begin
            if (hits[i])
            begin
                hitColor = color[i];
            end
        end
    end

endmodule : layerPriority

`default_nettype wire

/* design/screenRegion.sv */
`default_nettype none

// visible window and border band of the scan
module screenRegion
(
    input  wire displayPkg::coord_t hCount,
    input  wire displayPkg::coord_t vCount,
    input  wire displayPkg::coord_t borderWidth,
    input  wire displayPkg::coord_t borderHeight,
    output logic                    visible,
    output logic                    onBorder
);
    import displayPkg::*;

    logic   hInside;
    logic   vInside;
    coord_t fromLeft;
    coord_t fromRight;
    coord_t fromTop;
    coord_t fromBottom;

    assign hInside = (hCount >= H_ACTIVE_START) && (hCount <= H_ACTIVE_END);
    assign vInside = (vCount >= V_ACTIVE_START) && (vCount <= V_ACTIVE_END);
    assign visible = hInside && vInside;

    //////////////////////////////////////////////////////////////////////
    // distance to each window edge
    //////////////////////////////////////////////////////////////////////

    // only meaningful inside the window, where none of these can wrap
    assign fromLeft   = hCount - H_ACTIVE_START;
    assign fromRight  = H_ACTIVE_END - hCount;
    assign fromTop    = vCount - V_ACTIVE_START;
    assign fromBottom = V_ACTIVE_END - vCount;

    // band is inclusive of the thickness itself
    always_comb
    begin
        onBorder = 1'b0;
        if (visible)
        begin
            onBorder = (fromLeft <= borderWidth) || (fromRight <= borderWidth)
                    || (fromTop <= borderHeight) || (fromBottom <= borderHeight);
        end
    end

endmodule : screenRegion

`default_nettype wire

/* design/pixelSelect.sv */
`default_nettype none

// per-pixel colour select with one register stage
module pixelSelect
(
    input  wire                       clk,
    input  wire                       rstN,

    input  wire displayPkg::coord_t   hCount,
    input  wire displayPkg::coord_t   vCount,
    input  wire displayPkg::coord_t   borderWidth,
    input  wire displayPkg::coord_t   borderHeight,

    input  wire displayPkg::coord_t   playerPosH,
    input  wire displayPkg::coord_t   playerPosV,
    input  wire displayPkg::coord_t   playerWidth,
    input  wire displayPkg::coord_t   playerHeight,
    input  wire displayPkg::selCode_t playerColor,

    input  wire displayPkg::coord_t   wallPosH    [displayPkg::NUM_OBJECTS],
    input  wire displayPkg::coord_t   wallPosV    [displayPkg::NUM_OBJECTS],
    input  wire displayPkg::coord_t   wallWidth   [displayPkg::NUM_OBJECTS],
    input  wire displayPkg::coord_t   wallHeight  [displayPkg::NUM_OBJECTS],
    input  wire displayPkg::selCode_t wallColor   [displayPkg::NUM_OBJECTS],

    input  wire displayPkg::coord_t   scrollPosH  [displayPkg::NUM_OBJECTS],
    input  wire displayPkg::coord_t   scrollPosV  [displayPkg::NUM_OBJECTS],
    input  wire displayPkg::coord_t   scrollWidth [displayPkg::NUM_OBJECTS],
    input  wire displayPkg::coord_t   scrollHeight[displayPkg::NUM_OBJECTS],
    input  wire displayPkg::selCode_t scrollColor [displayPkg::NUM_OBJECTS],

    output displayPkg::selCode_t      sel
);
    import displayPkg::*;

    logic     visible;
    logic     onBorder;
    logic     playerHit;
    logic     wallHit;
    selCode_t wallHitColor;
    logic     scrollHit;
    selCode_t scrollHitColor;
    selCode_t nextSel;

    //////////////////////////////////////////////////////////////////////
    // region and object tests
    //////////////////////////////////////////////////////////////////////

    screenRegion uRegion
    (
        .hCount       (hCount),
        .vCount       (vCount),
        .borderWidth  (borderWidth),
        .borderHeight (borderHeight),
        .visible      (visible),
        .onBorder     (onBorder)
    );

    objectHitTest uPlayer
    (
        .hCount (hCount),
        .vCount (vCount),
        .posH   (playerPosH),
        .posV   (playerPosV),
        .width  (playerWidth),
        .height (playerHeight),
        .hit    (playerHit)
    );

    layerPriority uWalls
    (
        .hCount   (hCount),
        .vCount   (vCount),
        .posH     (wallPosH),
        .posV     (wallPosV),
        .width    (wallWidth),
        .height   (wallHeight),
        .color    (wallColor),
        .anyHit   (wallHit),
        .hitColor (wallHitColor)
    );

    layerPriority uScrolls
    (
        .hCount   (hCount),
        .vCount   (vCount),
        .posH     (scrollPosH),
        .posV     (scrollPosV),
        .width    (scrollWidth),
        .height   (scrollHeight),
        .color    (scrollColor),
        .anyHit   (scrollHit),
        .hitColor (scrollHitColor)
    );

    //////////////////////////////////////////////////////////////////////
    // priority and output stage
    //////////////////////////////////////////////////////////////////////

    // blank, border, player, walls, scrolls, then blank
    always_comb
    begin
        if (!visible)
        begin
            nextSel = SEL_BLANK;
        end
        else if (onBorder)
        begin
            nextSel = SEL_BORDER;
        end
        else if (playerHit)
        begin
            nextSel = playerColor;
        end
        else if (wallHit)
        begin
            nextSel = wallHitColor;
        end
        else if (scrollHit)
        begin
            nextSel = scrollHitColor;
        end
        else
        begin
            nextSel = SEL_BLANK;
        end
    end

    // one cycle from counts to sel
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            sel <= SEL_BLANK;
        end
        else
        begin
            sel <= nextSel;
        end
    end

endmodule : pixelSelect

`default_nettype wire

/* verif/pixelModel.svh */
`ifndef PIXEL_MODEL_SVH
`define PIXEL_MODEL_SVH

// one xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// inclusive rectangle, position relative to the visible origin
function automatic bit insideRect(input int h, input int v, input int ph, input int pv,
                                  input int w, input int ht);
    int left;
    int top;
    left = int'(H_ACTIVE_START) + ph;
    top  = int'(V_ACTIVE_START) + pv;
    return (h >= left) && (h <= left + w) && (v >= top) && (v <= top + ht);
endfunction

// expected code for the values now driven on the DUT inputs
function automatic selCode_t modelSel();
    int h;
    int v;
    int bw;
    int bh;
    h  = hCount;
    v  = vCount;
    bw = borderWidth;
    bh = borderHeight;
    if (h < int'(H_ACTIVE_START) || h > int'(H_ACTIVE_END)
        || v < int'(V_ACTIVE_START) || v > int'(V_ACTIVE_END))
        return SEL_BLANK;
    if (h - int'(H_ACTIVE_START) <= bw || int'(H_ACTIVE_END) - h <= bw
        || v - int'(V_ACTIVE_START) <= bh || int'(V_ACTIVE_END) - v <= bh)
        return SEL_BORDER;
    if (insideRect(h, v, playerPosH, playerPosV, playerWidth, playerHeight))
        return playerColor;
    // lowest index first within each layer
    for (int i = 0; i < NUM_OBJECTS; i++)
        if (insideRect(h, v, wallPosH[i], wallPosV[i], wallWidth[i], wallHeight[i]))
            return wallColor[i];
    for (int i = 0; i < NUM_OBJECTS; i++)
        if (insideRect(h, v, scrollPosH[i], scrollPosV[i], scrollWidth[i], scrollHeight[i]))
            return scrollColor[i];
    return SEL_BLANK;
endfunction

`endif

/* verif/pixelSelectTb.sv */
`default_nettype none

module pixelSelectTb;
    import displayPkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RANDOM_PIXELS   = 4000;
    localparam int DIRECTED_PIXELS = 27;
    localparam int HS              = int'(H_ACTIVE_START);
    localparam int VS              = int'(V_ACTIVE_START);

    logic        clk;
    logic        rstN;
    coord_t      hCount;
    coord_t      vCount;
    coord_t      borderWidth;
    coord_t      borderHeight;
    coord_t      playerPosH;
    coord_t      playerPosV;
    coord_t      playerWidth;
    coord_t      playerHeight;
    selCode_t    playerColor;
    coord_t      wallPosH     [NUM_OBJECTS];
    coord_t      wallPosV     [NUM_OBJECTS];
    coord_t      wallWidth    [NUM_OBJECTS];
    coord_t      wallHeight   [NUM_OBJECTS];
    selCode_t    wallColor    [NUM_OBJECTS];
    coord_t      scrollPosH   [NUM_OBJECTS];
    coord_t      scrollPosV   [NUM_OBJECTS];
    coord_t      scrollWidth  [NUM_OBJECTS];
    coord_t      scrollHeight [NUM_OBJECTS];
    selCode_t    scrollColor  [NUM_OBJECTS];
    selCode_t    sel;
    logic [31:0] rngState;

    pixelSelect DUT (.*);

    `include "pixelModel.svh"

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // uniform value in 0..n-1
    function automatic int randBelow(input int n);
        rngState = xorshift32(rngState);
        return int'(rngState % n);
    endfunction

    task automatic compareSel(input string name, input selCode_t expected);
        if (sel !== expected)
        begin
            $display("mismatch %s expected %0d actual %0d", name, expected, sel);
            $display("*** FAILED ***");
            $fatal(1, "sel check failed");
        end
    endtask

    // drive one pixel now, check it one falling edge later
    task automatic runPixel(input string name, input int h, input int v);
        selCode_t expected;
        hCount   = coord_t'(h);
        vCount   = coord_t'(v);
        expected = modelSel();
        @(negedge clk);
        compareSel(name, expected);
    endtask

    task automatic placeWall(input int i, input int ph, input int pv,
                             input int w, input int ht, input int c);
        wallPosH[i]   = coord_t'(ph);
        wallPosV[i]   = coord_t'(pv);
        wallWidth[i]  = coord_t'(w);
        wallHeight[i] = coord_t'(ht);
        wallColor[i]  = selCode_t'(c);
    endtask

    task automatic placeScroll(input int i, input int ph, input int pv,
                               input int w, input int ht, input int c);
        scrollPosH[i]   = coord_t'(ph);
        scrollPosV[i]   = coord_t'(pv);
        scrollWidth[i]  = coord_t'(w);
        scrollHeight[i] = coord_t'(ht);
        scrollColor[i]  = selCode_t'(c);
    endtask

    // leftover objects collapse onto the top left corner, which is always border
    task automatic clearScene();
        for (int i = 0; i < NUM_OBJECTS; i++)
        begin
            placeWall(i, 0, 0, 0, 0, 0);
            placeScroll(i, 0, 0, 0, 0, 0);
        end
    endtask

    task automatic randomizeObjects();
        borderWidth  = coord_t'(randBelow(16));
        borderHeight = coord_t'(randBelow(16));
        playerPosH   = coord_t'(randBelow(641));
        playerPosV   = coord_t'(randBelow(481));
        playerWidth  = coord_t'(randBelow(64));
        playerHeight = coord_t'(randBelow(64));
        playerColor  = selCode_t'(randBelow(8));
        for (int i = 0; i < NUM_OBJECTS; i++)
        begin
            placeWall(i, randBelow(641), randBelow(481), randBelow(64), randBelow(64),
                      randBelow(8));
            placeScroll(i, randBelow(641), randBelow(481), randBelow(64), randBelow(64),
                        randBelow(8));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////////////////

    initial
    begin
        #((RANDOM_PIXELS + DIRECTED_PIXELS + 10) * CLK_PERIOD * 2);
        $display("timeout: the pixel checks did not finish in time");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////

    initial
    begin
        rngState     = 32'hece40384;
        rstN         = 1'b0;
        borderWidth  = 10'd4;
        borderHeight = 10'd3;
        clearScene();
        playerPosH   = 10'd100;
        playerPosV   = 10'd100;
        playerWidth  = 10'd20;
        playerHeight = 10'd10;
        playerColor  = 3'd1;
        // player pixel under reset, must still read blank
        hCount       = coord_t'(HS + 110);
        vCount       = coord_t'(VS + 105);
        repeat (2)
        begin
            @(negedge clk);
            compareSel("reset", SEL_BLANK);
        end
        rstN = 1'b1;
        runPixel("first pixel after reset", HS + 110, VS + 105);

        repeat (RANDOM_PIXELS)
        begin
            randomizeObjects();
            runPixel("random", randBelow(800), randBelow(525));
        end

        // directed scene
        borderWidth  = 10'd4;
        borderHeight = 10'd3;
        clearScene();
        playerPosH   = 10'd100;
        playerPosV   = 10'd100;
        playerWidth  = 10'd20;
        playerHeight = 10'd10;
        playerColor  = 3'd1;
        placeWall(0, 110, 105, 30, 30, 2);
        placeWall(1, 110, 105, 30, 30, 3);
        placeWall(2, 200, 200, 10, 10, 4);
        placeWall(3, 205, 205, 10, 10, 5);
        placeWall(4, 630, 400, 63, 20, 2);
        placeWall(5, 0, 100, 10, 10, 3);
        placeScroll(0, 115, 108, 40, 40, 7);
        placeScroll(1, 300, 300, 0, 0, 5);

        // points outside the window sit in line with a border band
        runPixel("left of window", HS - 1, VS + 2);
        runPixel("right of window over wall", HS + 641, VS + 410);
        runPixel("above window", HS + 2, VS - 1);
        runPixel("below window", HS + 2, VS + 481);
        runPixel("left border limit", HS + 4, VS + 105);
        runPixel("past left border", HS + 5, VS + 105);
        runPixel("right border limit", HS + 636, VS + 410);
        runPixel("past right border", HS + 635, VS + 410);
        runPixel("top border limit", HS + 300, VS + 3);
        runPixel("past top border", HS + 300, VS + 4);
        runPixel("bottom border limit", HS + 300, VS + 477);
        runPixel("past bottom border", HS + 300, VS + 476);
        runPixel("player over wall and scroll", HS + 117, VS + 109);
        runPixel("wall over scroll", HS + 125, VS + 120);
        runPixel("scroll alone", HS + 150, VS + 140);
        runPixel("overlapping walls", HS + 207, VS + 207);
        runPixel("wall right edge", HS + 215, VS + 213);
        runPixel("past wall right edge", HS + 216, VS + 213);
        runPixel("wall left edge", HS + 205, VS + 213);
        runPixel("past wall left edge", HS + 204, VS + 213);
        runPixel("wall top edge", HS + 213, VS + 205);
        runPixel("past wall top edge", HS + 213, VS + 204);
        runPixel("wall bottom edge", HS + 213, VS + 215);
        runPixel("past wall bottom edge", HS + 213, VS + 216);
        runPixel("zero-size scroll corner", HS + 300, VS + 300);
        runPixel("right of zero-size scroll", HS + 301, VS + 300);
        runPixel("below zero-size scroll", HS + 300, VS + 301);

        $display("*** PASSED ***");
        $finish;
    end

endmodule : pixelSelectTb

`default_nettype wire

/* filelist.f */
+incdir+verif
design/displayPkg.sv
design/objectHitTest.sv
design/layerPriority.sv
design/screenRegion.sv
design/pixelSelect.sv
verif/pixelSelectTb.sv
